//--- rtl/tq_macros.svh
`ifndef TQ_MACROS_SVH
`define TQ_MACROS_SVH

// ==========================================================================
// sample and arithmetic widths
// ==========================================================================

// pixel and prediction, unsigned
`define TQ_PIX_W 8
// pixel minus prediction, signed
`define TQ_RES_W 9
// transform output, 16 * 255 plus sign
`define TQ_COEF_W 13
// quantized level, signed
`define TQ_LVL_W 16
// |coef| * MF + f, unsigned
`define TQ_PROD_W 28
// quantizer step index
`define TQ_QP_W 5

// samples in one 4x4 block
`define TQ_BLK_N 16
// qbits for qp 0..5, grows by one per six qp
`define TQ_QBITS_BASE 15

`endif

//--- rtl/tq_types_pkg.sv
`include "tq_macros.svh"

package tq_types_pkg;

    // ==========================================================================
    // sample words of the block path
    // ==========================================================================

    // raw pixel or prediction
    typedef logic [`TQ_PIX_W-1:0] pixel_t;

    // signed difference, -255..255
    typedef logic signed [`TQ_RES_W-1:0] residual_t;

    // one transform coefficient
    typedef logic signed [`TQ_COEF_W-1:0] coef_t;

    // one output level
    typedef logic signed [`TQ_LVL_W-1:0] level_t;

    // whole block in raster order, slot = row * 4 + col
    typedef residual_t residual_blk_t [`TQ_BLK_N];

    // ==========================================================================
    // coefficient position
    // ==========================================================================

    // row in the upper two bits, so it lines up with the flat index
    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
    } pos_rc_t;

    // flat view picks basis pair and output order, row/col view picks qclass
    typedef union packed {
        logic [3:0] idx;
        pos_rc_t    rc;
    } pos_u;

endpackage

//--- rtl/tq_quant_pkg.sv
`include "tq_macros.svh"

package tq_quant_pkg;

    typedef logic [`TQ_QP_W-1:0] qp_t;

    // a: row and col even, b: both odd, c: mixed
    typedef enum logic [1:0] {
        class_a,
        class_b,
        class_c
    } qclass_e;

    // qp / 6, saturating at 4 like the rounding and qbits tables
    function automatic logic [2:0] qp_group(qp_t qp);
        logic [2:0] grp;
        grp = 3'(qp / 6);
        if (grp > 3'd4) begin
            grp = 3'd4;
        end
        return grp;
    endfunction

    // qp mod 6, selects the MF row
    function automatic logic [2:0] qp_rem(qp_t qp);
        return 3'(qp % 6);
    endfunction

    function automatic logic [`TQ_PROD_W-1:0] by_class(qclass_e cls, int a, int b, int c);
        int v;
        case (cls)
            class_a: v = a;
            class_b: v = b;
            default: v = c;
        endcase
        return `TQ_PROD_W'(v);
    endfunction

    // ==========================================================================
    // quantizer tables
    // ==========================================================================

    // multiplication factor per qp mod 6 and class
    function automatic logic [`TQ_PROD_W-1:0] mf_of(qp_t qp, qclass_e cls);
        logic [`TQ_PROD_W-1:0] mf;
        case (qp_rem(qp))
            3'd0:    mf = by_class(cls, 13107, 5243, 8066);
            3'd1:    mf = by_class(cls, 11916, 4660, 7490);
            3'd2:    mf = by_class(cls, 10082, 4194, 6554);
            3'd3:    mf = by_class(cls, 9362, 3647, 5825);
            3'd4:    mf = by_class(cls, 8192, 3355, 5243);
            default: mf = by_class(cls, 7282, 2893, 4559);
        endcase
        return mf;
    endfunction

    function automatic logic [4:0] qbits_of(qp_t qp);
        return 5'(`TQ_QBITS_BASE) + 5'(qp_group(qp));
    endfunction

    // rounding offset, roughly 2^qbits / 3
    function automatic logic [`TQ_PROD_W-1:0] f_of(qp_t qp);
        int v;
        case (qp_group(qp))
            3'd0:    v = 10922;
            3'd1:    v = 21845;
            3'd2:    v = 43690;
            3'd3:    v = 87381;
            default: v = 174762;
        endcase
        return `TQ_PROD_W'(v);
    endfunction

endpackage

//--- rtl/coef_if.sv
`timescale 1ns/1ps

// one transform coefficient per valid cycle, no back-pressure
interface coef_if;

    // strobe, one coefficient per high cycle
    logic                 valid;
    tq_types_pkg::coef_t  coef;
    // position 0..15 within the block
    tq_types_pkg::pos_u   pos;
    // qp of the block this coefficient belongs to
    tq_quant_pkg::qp_t    qp;

    // transform side
    modport src (
        output valid,
        output coef,
        output pos,
        output qp
    );

    // quantizer side
    modport dst (
        input valid,
        input coef,
        input pos,
        input qp
    );

endinterface

//--- rtl/residual_collect.sv
`timescale 1ns/1ps
`include "tq_macros.svh"

module residual_collect (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  tq_types_pkg::pixel_t        pixel,
    input  tq_types_pkg::pixel_t        pred,
    input  tq_quant_pkg::qp_t           qp,
    output logic                        blk_valid,
    output tq_types_pkg::residual_blk_t blk,
    output tq_quant_pkg::qp_t           blk_qp
);

    // ==========================================================================
    // residual
    // ==========================================================================

    // slot of the next sample, raster order
    logic [3:0] cnt;
    logic       last_slot;
    tq_types_pkg::residual_t res;

    // both zero-extended, 9-bit two's complement difference
    assign res = tq_types_pkg::residual_t'({1'b0, pixel} - {1'b0, pred});

    assign last_slot = (cnt == 4'(`TQ_BLK_N - 1));

    // ==========================================================================
    // sample counter and block strobe
    // ==========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            blk_valid <= 1'b0;
        end else begin
            // one-cycle pulse after the 16th sample
            blk_valid <= in_valid && last_slot;
            // idle gaps hold the count
            if (in_valid) begin
                cnt <= cnt + 4'd1;
            end
        end
    end

    // ==========================================================================
    // block storage
    // ==========================================================================

    // next block may start writing on the load edge
    // transform samples the old contents on that same edge
    always_ff @(posedge clk) begin
        if (in_valid) begin
            blk[cnt] <= res;
            // qp taken with the first sample only
            if (cnt == 4'd0) begin
                blk_qp <= qp;
            end
        end
    end

endmodule

//--- rtl/hadamard_4x4.sv
`timescale 1ns/1ps
`include "tq_macros.svh"

module hadamard_4x4 (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        blk_valid,
    input  tq_types_pkg::residual_blk_t blk,
    input  tq_quant_pkg::qp_t           blk_qp,
    coef_if.src                         co
);

    // negative taps of each basis row, bit r set means -1
    // rows ++++, ++--, +--+, +-+-
    localparam logic [3:0] h_neg [4] = '{4'b0000, 4'b1100, 4'b0110, 4'b1010};

    tq_types_pkg::residual_blk_t blk_q;
    tq_quant_pkg::qp_t           qp_q;
    tq_types_pkg::pos_u          pos_q;
    // high while positions 0..15 are being produced
    logic                        busy;
    tq_types_pkg::coef_t         coef_sum;

    // ==========================================================================
    // block hold and position counter
    // ==========================================================================

    always_ff @(posedge clk) begin
        if (blk_valid) begin
            blk_q <= blk;
            qp_q  <= blk_qp;
        end
    end

    // a new load may land on the edge that emits position 15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            pos_q <= '0;
        end else if (blk_valid) begin
            busy  <= 1'b1;
            pos_q <= '0;
        end else if (busy) begin
            pos_q.idx <= pos_q.idx + 4'd1;
            if (pos_q.idx == 4'(`TQ_BLK_N - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // ==========================================================================
    // one coefficient per cycle
    // ==========================================================================

    // u from the upper index bits applies along rows, v along columns
    always_comb begin
        tq_types_pkg::coef_t term;
        coef_sum = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // sign-extend before accumulating
                term = blk_q[r * 4 + c];
                if (h_neg[pos_q.idx[3:2]][r] ^ h_neg[pos_q.idx[1:0]][c]) begin
                    coef_sum = coef_sum - term;
                end else begin
                    coef_sum = coef_sum + term;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            co.valid <= 1'b0;
        end else begin
            co.valid <= busy;
        end
    end

    // payload follows the counter, qualified by valid
    always_ff @(posedge clk) begin
        co.coef <= coef_sum;
        co.pos  <= pos_q;
        co.qp   <= qp_q;
    end

endmodule

//--- rtl/quantizer.sv
`timescale 1ns/1ps
`include "tq_macros.svh"

module quantizer (
    input  logic                 clk,
    input  logic                 rst_n,
    coef_if.dst                  ci,
    output logic                 out_valid,
    output tq_types_pkg::level_t out_level
);

    logic                    sign;
    logic [`TQ_COEF_W-1:0]   mag;
    tq_quant_pkg::qclass_e   cls;
    logic [`TQ_PROD_W-1:0]   mf;
    logic [`TQ_PROD_W-1:0]   f;
    logic [4:0]              qbits;
    logic [`TQ_PROD_W-1:0]   scaled;
    logic [`TQ_LVL_W-1:0]    z;
    tq_types_pkg::level_t    level;

    // ==========================================================================
    // magnitude and class
    // ==========================================================================

    assign sign = ci.coef[`TQ_COEF_W-1];
    // -4096 cannot occur, so the 13-bit negate is safe
    assign mag  = sign ? -ci.coef : ci.coef;

    // class from the parity of row and column
    always_comb begin
        if (!ci.pos.rc.row[0] && !ci.pos.rc.col[0]) begin
            cls = tq_quant_pkg::class_a;
        end else if (ci.pos.rc.row[0] && ci.pos.rc.col[0]) begin
            cls = tq_quant_pkg::class_b;
        end else begin
            cls = tq_quant_pkg::class_c;
        end
    end

    // ==========================================================================
    // (|coef| * MF + f) >> qbits
    // ==========================================================================

    assign mf     = tq_quant_pkg::mf_of(ci.qp, cls);
    assign f      = tq_quant_pkg::f_of(ci.qp);
    assign qbits  = tq_quant_pkg::qbits_of(ci.qp);
    assign scaled = (`TQ_PROD_W'(mag) * mf + f) >> qbits;

    // at most about 1.7K, fits the level width
    assign z      = scaled[`TQ_LVL_W-1:0];
    // coefficient sign put back on
    assign level  = sign ? -z : z;

    // ==========================================================================
    // output register
    // ==========================================================================

    // level held at zero between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_level <= '0;
        end else begin
            out_valid <= ci.valid;
            out_level <= ci.valid ? level : '0;
        end
    end

endmodule

//--- rtl/intra_tq_top.sv
`timescale 1ns/1ps

module intra_tq_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  tq_types_pkg::pixel_t pixel,
    input  tq_types_pkg::pixel_t pred,
    input  tq_quant_pkg::qp_t    qp,
    output logic                 out_valid,
    output tq_types_pkg::level_t out_level
);

    // ==========================================================================
    // collect -> transform -> quantize
    // ==========================================================================

    // block handoff, one pulse per 16 samples
    logic                        blk_valid;
    tq_types_pkg::residual_blk_t blk;
    tq_quant_pkg::qp_t           blk_qp;

    // coefficient stream
    coef_if coef_bus ();

    residual_collect u_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pixel     (pixel),
        .pred      (pred),
        .qp        (qp),
        .blk_valid (blk_valid),
        .blk       (blk),
        .blk_qp    (blk_qp)
    );

    // coefficient k after load edge + 1 + k
    hadamard_4x4 u_xform (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk       (blk),
        .blk_qp    (blk_qp),
        .co        (coef_bus.src)
    );

    // one more register stage to the pins
    quantizer u_quant (
        .clk       (clk),
        .rst_n     (rst_n),
        .ci        (coef_bus.dst),
        .out_valid (out_valid),
        .out_level (out_level)
    );

endmodule

//--- tb/tq_checker.sv
`timescale 1ns/1ps

// compares every out_valid cycle against the expected level queue
module tq_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 out_valid,
    input tq_types_pkg::level_t out_level
);

    // expected levels, pushed by the reader per completed block
    int exp_q[$];
    int err_count   = 0;
    int level_count = 0;
    int exp_v;

    task automatic push_expected(input int v);
        exp_q.push_back(v);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // ==========================================================================
    // output sampling, half a cycle after the DUT edge
    // ==========================================================================

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("time %0t: level %0d came out with no block outstanding",
                         $time, int'(out_level));
                err_count++;
            end else begin
                exp_v = exp_q.pop_front();
                if (int'(out_level) != exp_v) begin
                    $display("Error at time %0t: out_level (pos %0d) expected %0d, actual %0d",
                             $time, level_count % 16, exp_v, int'(out_level));
                    err_count++;
                end
                level_count++;
            end
        end else if (out_level != '0) begin
            // idle level must read zero
            $display("Error at time %0t: out_level expected 0, actual %0d",
                     $time, int'(out_level));
            err_count++;
        end
    end

endmodule

//--- tb/tb_intra_tq.sv
`timescale 1ns/1ps

module tb_intra_tq;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    tq_types_pkg::pixel_t pixel;
    tq_types_pkg::pixel_t pred;
    tq_quant_pkg::qp_t    qp;
    logic                 out_valid;
    tq_types_pkg::level_t out_level;

    // case storage with one entry per block
    int cases_qp  [64];
    int cases_pix [64][16];
    int cases_prd [64][16];
    int cases_exp [64][16];
    int nblk;
    int seed   = 3;
    int cycles = 0;
    int limit  = 1000;
    int fd;
    int rc;
    int v;
    // set when the case file stops inside a block
    logic short_file;

    intra_tq_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pixel     (pixel),
        .pred      (pred),
        .qp        (qp),
        .out_valid (out_valid),
        .out_level (out_level)
    );

    tq_checker u_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_level (out_level)
    );

    always #10 clk = ~clk;

    // ==========================================================================
    // cycle limit
    // ==========================================================================

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d levels never came out",
                     cycles, u_check.pending());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // next integer of the case file
    task automatic read_field(output int w);
        rc = $fscanf(fd, "%d", w);
        if (rc != 1) begin
            w          = 0;
            short_file = 1'b1;
        end
    endtask

    // n idle cycles with pixel and qp scrambled
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
            pixel    = tq_types_pkg::pixel_t'($random(seed));
            qp       = tq_quant_pkg::qp_t'($random(seed));
        end
    endtask

    // one block with random gaps between samples
    // qp after the first sample is noise
    task automatic send_block(input int b);
        for (int i = 0; i < 16; i++) begin
            if (i != 0) begin
                idle_cycles($unsigned($random(seed)) % 4);
            end
            @(negedge clk);
            in_valid = 1'b1;
            pixel    = tq_types_pkg::pixel_t'(cases_pix[b][i]);
            pred     = tq_types_pkg::pixel_t'(cases_prd[b][i]);
            qp       = (i == 0) ? tq_quant_pkg::qp_t'(cases_qp[b])
                                : tq_quant_pkg::qp_t'($random(seed));
        end
        for (int k = 0; k < 16; k++) begin
            u_check.push_expected(cases_exp[b][k]);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        pixel      = '0;
        pred       = '0;
        qp         = '0;
        nblk       = 0;
        short_file = 1'b0;
        fd = $fopen("tb/tq_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file tb/tq_cases.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            // qp, 16 pixels, 16 predictions, then 16 levels
            while (nblk < 64 && !short_file && $fscanf(fd, "%d", v) == 1) begin
                cases_qp[nblk] = v;
                for (int i = 0; i < 16; i++) begin
                    read_field(cases_pix[nblk][i]);
                end
                for (int i = 0; i < 16; i++) begin
                    read_field(cases_prd[nblk][i]);
                end
                for (int i = 0; i < 16; i++) begin
                    read_field(cases_exp[nblk][i]);
                end
                if (!short_file) begin
                    nblk++;
                end
            end
            $fclose(fd);
            if (short_file) begin
                $display("case file tb/tq_cases.txt ends inside block %0d", nblk);
            end
            limit = nblk * (16 * 4 + 20) + 100;
            repeat (8) @(negedge clk);
            rst_n = 1'b1;
            idle_cycles(5);
            for (int b = 0; b < nblk; b++) begin
                send_block(b);
                // every fourth block follows with no gap
                if (b % 4 != 3) begin
                    idle_cycles($unsigned($random(seed)) % 4);
                end
            end
            idle_cycles(1);
            while (u_check.pending() != 0) begin
                @(negedge clk);
            end
            // window for stray levels
            idle_cycles(20);
            $display("blocks %0d, levels checked %0d, errors %0d",
                     nblk, u_check.level_count, u_check.err_count);
            if (u_check.err_count == 0 && nblk > 0 && !short_file) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

//--- tb/tq_cases.txt
0 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 110 110 110 110 110 110 110 110 110 110 110 110 110 110 110 110 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
64 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 90 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
-64 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
14 110 110 110 110 110 110 110 110 110 110 110 110 110 110 110 110 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
12 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
28 110 110 110 110 110 110 110 110 110 110 110 110 110 110 110 110 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1632 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255
-1632 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
28 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255
-64 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 150 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50
40 24 40 24 24 16 24 16 40 24 40 24 24 16 24 16
0 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 150 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50
-40 -24 -40 -24 -24 -16 -24 -16 -40 -24 -40 -24 -24 -16 -24 -16
14 150 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50
8 5 8 5 5 3 5 3 8 5 8 5 5 3 5 3
0 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 150 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50
40 -24 40 -24 -24 16 -24 16 40 -24 40 -24 -24 16 -24 16
0 110 110 90 90 110 110 90 90 110 110 90 90 110 110 90 90 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
0 39 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 110 90 110 90 110 90 110 90 110 90 110 90 110 90 110 90 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
0 0 0 39 0 0 0 0 0 0 0 0 0 0 0 0
0 110 90 110 90 90 110 90 110 110 90 110 90 90 110 90 110 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 25
28 110 90 110 90 90 110 90 110 110 90 110 90 90 110 90 110 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1

//--- project.f
+incdir+rtl
rtl/tq_types_pkg.sv
rtl/tq_quant_pkg.sv
rtl/coef_if.sv
rtl/residual_collect.sv
rtl/hadamard_4x4.sv
rtl/quantizer.sv
rtl/intra_tq_top.sv
tb/tq_checker.sv
tb/tb_intra_tq.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_intra_tq -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
